//--- filelist.f
rtl/pcm_pkg.sv
rtl/pcm_regfile.sv
rtl/pcm_channel_seq.sv
rtl/pcm_mixer.sv
rtl/pcm_sound.sv
testbench/pcm_sound_assert.sv
testbench/tb_pcm_sound.sv

//--- rtl/pcm_channel_seq.sv
// Channel sequencer: pipe strobe, 16-step walk, address stepping, end handling, ROM fetch
`timescale 1ns/1ps
`default_nettype none

module pcm_channel_seq (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    // register file port 1
    output logic [6:0]        cfg_addr,
    output logic              cfg_we,
    output logic [7:0]        cfg_din,
    input  logic [7:0]        cfg_data,
    // sample ROM
    output logic [18:0]       rom_addr,
    output logic              rom_cs,
    // mixer
    output logic              pipe_stb,
    output pcm_pkg::mix_cmd_t mix_cmd
);

    logic        cen_half;   // toggles on every cen
    logic        step_tick;  // one step per second cen
    logic [$clog2(pcm_pkg::num_steps)-1:0] st;
    logic [$clog2(pcm_pkg::num_ch)-1:0]    cur_ch;
    logic [3:0]  reg_off;

    // working copy of the current channel
    logic [7:0]  cfg_en;
    logic [23:0] cur_addr;
    logic [7:0]  delta;
    logic [23:8] loop_addr;

    assign cfg_addr = {reg_off[3], cur_ch, reg_off[2:0]};

    always_comb begin
        case (st)
            4'd0:    reg_off = pcm_pkg::reg_enable;
            4'd1:    reg_off = pcm_pkg::reg_addr_lo;
            4'd2:    reg_off = pcm_pkg::reg_addr_mid;
            4'd3:    reg_off = pcm_pkg::reg_addr_hi;
            4'd4:    reg_off = pcm_pkg::reg_delta;
            4'd5:    reg_off = pcm_pkg::reg_loop_mid;
            4'd6:    reg_off = pcm_pkg::reg_loop_hi;
            4'd7:    reg_off = pcm_pkg::reg_end_hi;
            4'd8:    reg_off = pcm_pkg::reg_enable;   // write-back
            4'd9:    reg_off = pcm_pkg::reg_addr_lo;  // write-back
            4'd10:   reg_off = pcm_pkg::reg_addr_mid; // write-back
            4'd11:   reg_off = pcm_pkg::reg_addr_hi;  // write-back
            4'd12:   reg_off = pcm_pkg::reg_vol_l;
            4'd13:   reg_off = pcm_pkg::reg_vol_r;
            default: reg_off = 4'd0;
        endcase
    end

    always_comb begin
        cfg_we = (st >= 4'd8) && (st <= 4'd11);
        case (st)
            4'd8:    cfg_din = cfg_en;
            4'd9:    cfg_din = cur_addr[7:0];
            4'd10:   cfg_din = cur_addr[15:8];
            default: cfg_din = cur_addr[23:16];
        endcase
    end

    // channel working registers
    always_ff @(posedge clk) begin
        if (step_tick) begin
            case (st)
                4'd0: cfg_en            <= cfg_data;
                4'd1: cur_addr[7:0]     <= cfg_data;
                4'd2: cur_addr[15:8]    <= cfg_data;
                4'd3: cur_addr[23:16]   <= cfg_data;
                4'd4: delta             <= cfg_data;
                4'd5: loop_addr[15:8]   <= cfg_data;
                4'd6: loop_addr[23:16]  <= cfg_data;
                4'd7: begin
                    if (cur_addr[23:16] == cfg_data) begin  // end byte reached
                        if (cfg_en[pcm_pkg::en_one_shot]) begin
                            cfg_en[pcm_pkg::en_stop] <= 1'b1;
                            cur_addr[7:0]            <= 8'd0;
                        end else begin
                            cur_addr <= {loop_addr, 8'd0};
                        end
                    end
                end
                4'd8: cur_addr <= cur_addr + {16'd0, delta};
                default: ;
            endcase
        end
    end

    // step walk, ROM window and mixer commands
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen_half  <= 1'b0;
            step_tick <= 1'b0;
            st        <= '0;
            cur_ch    <= '0;
            rom_cs    <= 1'b0;
            rom_addr  <= '0;
            pipe_stb  <= 1'b0;
            mix_cmd   <= '0;
        end else begin
            if (cen) begin
                cen_half <= ~cen_half;
            end
            step_tick <= cen & ~cen_half;
            pipe_stb  <= step_tick;  // mixer sees the command one clock later
            if (step_tick) begin
                st             <= st + 4'd1;
                mix_cmd.op     <= pcm_pkg::mix_none;
                mix_cmd.data   <= cfg_data;
                mix_cmd.active <= ~cfg_en[pcm_pkg::en_stop];
                case (st)
                    4'd0: begin
                        if (cur_ch == 3'd0) begin
                            mix_cmd.op <= pcm_pkg::mix_flush;  // frame boundary
                        end
                    end
                    4'd8: begin
                        rom_addr <= {cfg_en[pcm_pkg::en_bank_lo +: 3], cur_addr[23:8]};
                        rom_cs   <= 1'b1;
                    end
                    4'd12: mix_cmd.op <= pcm_pkg::mix_vol_l;
                    4'd13: mix_cmd.op <= pcm_pkg::mix_vol_r;
                    4'd14: begin
                        rom_cs     <= 1'b0;  // byte is settled by now
                        mix_cmd.op <= pcm_pkg::mix_hold;
                    end
                    4'd15: begin
                        mix_cmd.op <= pcm_pkg::mix_add;
                        cur_ch     <= cur_ch + 3'd1;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/pcm_mixer.sv
// Stereo mixer: volume registers, signed products, saturating accumulation, output latch
`timescale 1ns/1ps
`default_nettype none

module pcm_mixer (
    input  logic                clk,
    input  logic                rst,
    input  logic                pipe_stb,
    input  pcm_pkg::mix_cmd_t   mix_cmd,
    input  logic [7:0]          rom_data,
    output logic signed [15:0]  snd_left,
    output logic signed [15:0]  snd_right,
    output logic                sample
);

    logic        [6:0]  vol_l;
    logic        [6:0]  vol_r;
    logic signed [7:0]  pcm;      // ROM byte centred on zero
    logic signed [15:0] prod_l;
    logic signed [15:0] prod_r;
    logic signed [15:0] hold_l;
    logic signed [15:0] acc_l;
    logic signed [15:0] acc_r;

    function automatic logic signed [15:0] clip_add(input logic signed [15:0] a,
                                                    input logic signed [15:0] b);
        logic signed [16:0] sum;
        sum = {a[15], a} + {b[15], b};
        if (sum[16] != sum[15]) begin
            clip_add = sum[16] ? 16'sh8000 : 16'sh7fff;
        end else begin
            clip_add = sum[15:0];
        end
    endfunction

    assign pcm    = $signed(rom_data - 8'h80);
    assign prod_l = $signed({1'b0, vol_l}) * pcm;
    assign prod_r = $signed({1'b0, vol_r}) * pcm;

    always_ff @(posedge clk) begin
        if (pipe_stb) begin
            case (mix_cmd.op)
                pcm_pkg::mix_vol_l: vol_l  <= mix_cmd.data[6:0];
                pcm_pkg::mix_vol_r: vol_r  <= mix_cmd.data[6:0];
                pcm_pkg::mix_hold:  hold_l <= prod_l;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc_l     <= '0;
            acc_r     <= '0;
            snd_left  <= '0;
            snd_right <= '0;
            sample    <= 1'b0;
        end else begin
            sample <= 1'b0;
            if (pipe_stb) begin
                case (mix_cmd.op)
                    pcm_pkg::mix_flush: begin
                        snd_left  <= acc_l;  // previous frame
                        snd_right <= acc_r;
                        acc_l     <= '0;
                        acc_r     <= '0;
                        sample    <= 1'b1;
                    end
                    pcm_pkg::mix_add: begin
                        if (mix_cmd.active) begin
                            acc_l <= clip_add(acc_l, hold_l);
                            acc_r <= clip_add(acc_r, prod_r);
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/pcm_pkg.sv
// PCM sound package: register offsets, enable bits, step and channel counts, mixer command
`default_nettype none

package pcm_pkg;

    // byte positions inside a channel's 16-byte window
    localparam logic [3:0] reg_vol_l    = 4'd2;
    localparam logic [3:0] reg_vol_r    = 4'd3;
    localparam logic [3:0] reg_loop_mid = 4'd4;  // loop address 15..8
    localparam logic [3:0] reg_loop_hi  = 4'd5;  // loop address 23..16
    localparam logic [3:0] reg_end_hi   = 4'd6;
    localparam logic [3:0] reg_delta    = 4'd7;
    localparam logic [3:0] reg_addr_lo  = 4'd11;
    localparam logic [3:0] reg_addr_mid = 4'd12;
    localparam logic [3:0] reg_addr_hi  = 4'd13;
    localparam logic [3:0] reg_enable   = 4'd14;

    // enable byte fields
    localparam int en_stop     = 0;  // channel silent
    localparam int en_one_shot = 1;  // stop at end, no loop
    localparam int en_bank_lo  = 4;  // 3-bit ROM bank in 6..4

    localparam int num_steps = 16;  // pipe steps per channel
    localparam int num_ch    = 8;

    typedef enum logic [2:0] {
        mix_none,
        mix_flush,  // publish and clear accumulators
        mix_vol_l,
        mix_vol_r,
        mix_hold,   // latch left product
        mix_add
    } mix_op_t;

    // one command per pipe strobe
    typedef struct packed {
        mix_op_t    op;
        logic [7:0] data;    // register byte for volume loads
        logic       active;  // channel not stopped
    } mix_cmd_t;

endpackage

`default_nettype wire

//--- rtl/pcm_regfile.sv
// Dual-port byte RAM holding the channel registers, CPU on port 0 and sequencer on port 1
`timescale 1ns/1ps
`default_nettype none

module pcm_regfile #(
    parameter int aw = 7
) (
    input  logic          clk,
    // port 0, CPU
    input  logic [aw-1:0] addr0,
    input  logic [7:0]    data0,
    input  logic          we0,
    output logic [7:0]    q0,
    // port 1, sequencer
    input  logic [aw-1:0] addr1,
    input  logic [7:0]    data1,
    input  logic          we1,
    output logic [7:0]    q1
);

    logic [7:0] mem [2**aw];

    always_ff @(posedge clk) begin
        if (we0) begin
            mem[addr0] <= data0;
        end
        if (we1) begin
            mem[addr1] <= data1;  // later write, port 1 wins a collision
        end
    end

    // registered reads, old data on a same-cycle write
    always_ff @(posedge clk) begin
        q0 <= mem[addr0];
        q1 <= mem[addr1];
    end

endmodule

`default_nettype wire

//--- rtl/pcm_sound.sv
// PCM sound top level: register file, channel sequencer and mixer behind the CPU and ROM ports
`timescale 1ns/1ps
`default_nettype none

module pcm_sound (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    // CPU bus
    input  logic [7:0]         cpu_addr,
    input  logic [7:0]         cpu_dout,
    output logic [7:0]         cpu_din,
    input  logic               cpu_rnw,
    input  logic               cpu_cs,
    // sample ROM
    output logic [18:0]        rom_addr,
    input  logic [7:0]         rom_data,
    output logic               rom_cs,
    // audio
    output logic signed [15:0] snd_left,
    output logic signed [15:0] snd_right,
    output logic               sample
);

    localparam int rf_aw = 7;  // 8 channels x 16 bytes

    logic              cpu_we;
    logic [rf_aw-1:0]  cpu_idx;
    logic [rf_aw-1:0]  cfg_addr;
    logic              cfg_we;
    logic [7:0]        cfg_din;
    logic [7:0]        cfg_data;
    logic              pipe_stb;
    pcm_pkg::mix_cmd_t mix_cmd;

    assign cpu_we  = cpu_cs & ~cpu_rnw;
    assign cpu_idx = {cpu_addr[7], cpu_addr[5:3], cpu_addr[2:0]};  // half, channel, byte

    pcm_regfile #(
        .aw(rf_aw)
    ) u_regfile (
        .clk   (clk),
        .addr0 (cpu_idx),
        .data0 (cpu_dout),
        .we0   (cpu_we),
        .q0    (cpu_din),
        .addr1 (cfg_addr),
        .data1 (cfg_din),
        .we1   (cfg_we),
        .q1    (cfg_data)
    );

    pcm_channel_seq u_seq (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .cfg_addr (cfg_addr),
        .cfg_we   (cfg_we),
        .cfg_din  (cfg_din),
        .cfg_data (cfg_data),
        .rom_addr (rom_addr),
        .rom_cs   (rom_cs),
        .pipe_stb (pipe_stb),
        .mix_cmd  (mix_cmd)
    );

    pcm_mixer u_mixer (
        .clk       (clk),
        .rst       (rst),
        .pipe_stb  (pipe_stb),
        .mix_cmd   (mix_cmd),
        .rom_data  (rom_data),
        .snd_left  (snd_left),
        .snd_right (snd_right),
        .sample    (sample)
    );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_pcm_sound -f filelist.f -o sim_pcm_sound
out=$(./obj_dir/sim_pcm_sound)
echo "$out"
if echo "$out" | grep -qx "Test passed"; then
    exit 0
else
    exit 1
fi

//--- testbench/pcm_sound_assert.sv
// Concurrent assertions on sample pulse, ROM fetch window and output timing of pcm_sound
`timescale 1ns/1ps
`default_nettype none

module pcm_sound_assert (
    input logic               clk,
    input logic               rst,
    input logic               sample,
    input logic               rom_cs,
    input logic signed [15:0] snd_left,
    input logic signed [15:0] snd_right
);

    // one-clock pulse per frame
    a_sample_single: assert property (@(posedge clk) disable iff (rst) sample |=> !sample)
        else $error("sample high for two clocks");

    // fetch window spans several pipe steps
    a_rom_window: assert property (@(posedge clk) disable iff (rst)
        $fell(rom_cs) |-> $past(rom_cs, 10))
        else $error("rom_cs window shorter than 10 clocks");

    a_left_stable: assert property (@(posedge clk) disable iff (rst)
        $changed(snd_left) |-> sample)
        else $error("snd_left changed without sample");

    a_right_stable: assert property (@(posedge clk) disable iff (rst)
        $changed(snd_right) |-> sample)
        else $error("snd_right changed without sample");

endmodule

bind pcm_sound pcm_sound_assert u_assert (.*);

`default_nettype wire

//--- testbench/tb_pcm_sound.sv
// Testbench for pcm_sound: clock, reset, ROM model, reference model and directed tests
`timescale 1ns/1ps
`default_nettype none

module tb_pcm_sound;

    logic               clk;
    logic               rst;
    logic               cen;
    logic [7:0]         cpu_addr;
    logic [7:0]         cpu_dout;
    logic [7:0]         cpu_din;
    logic               cpu_rnw;
    logic               cpu_cs;
    logic [18:0]        rom_addr;
    logic [7:0]         rom_data;
    logic               rom_cs;
    logic signed [15:0] snd_left;
    logic signed [15:0] snd_right;
    logic               sample;

    logic        use_fill;       // ROM answers a constant byte
    logic [7:0]  fill;
    logic [7:0]  regs_m [128];   // register image of the model
    logic [18:0] exp_rom [$];
    logic [18:0] rom_log [$];
    logic        rom_cs_d;
    int          rise_cnt;
    int          watch_ch;
    int          errors;
    int          test_err;
    int          exp_l;
    int          exp_r;

    pcm_sound i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        #2 cen = ~cen;  // every second clock
    end

    function automatic logic [7:0] rom_byte(input logic [18:0] a);
        logic [21:0] p;
        p = {3'd0, a} * 22'd7 + 22'd3;
        return p[7:0];
    endfunction

    always @(posedge clk) begin
        #2 rom_data = use_fill ? fill : rom_byte(rom_addr);
    end

    // log the ROM address at each request of the watched channel
    always @(negedge clk) begin
        if (rst) begin
            rise_cnt = 0;
            rom_log.delete();
        end else if (rom_cs && !rom_cs_d) begin
            if (rise_cnt % 8 == watch_ch) rom_log.push_back(rom_addr);
            rise_cnt++;
        end
        rom_cs_d = rom_cs;
    end

    function automatic logic [6:0] ridx(input int ch, input logic [3:0] off);
        return {off[3], ch[2:0], off[2:0]};
    endfunction

    function automatic int clip(input int v);
        if (v > 32767) return 32767;
        if (v < -32768) return -32768;
        return v;
    endfunction

    task automatic check(input string name, input string what, input int exp, input int act);
        if (exp != act) begin
            $display("Error %s: %s expected %0d actual %0d", name, what, exp, act);
            test_err++;
        end
    endtask

    task automatic write_reg(input int ch, input logic [3:0] off, input logic [7:0] v);
        @(posedge clk);
        #2;
        cpu_addr = {off[3], 1'b0, ch[2:0], off[2:0]};
        cpu_dout = v;
        cpu_rnw  = 1'b0;
        cpu_cs   = 1'b1;
        @(posedge clk);
        #2;
        cpu_cs  = 1'b0;
        cpu_rnw = 1'b1;
        regs_m[ridx(ch, off)] = v;
    endtask

    task automatic read_reg(input int ch, input logic [3:0] off, output logic [7:0] v);
        @(posedge clk);
        #2;
        cpu_addr = {off[3], 1'b0, ch[2:0], off[2:0]};
        cpu_rnw  = 1'b1;
        cpu_cs   = 1'b1;
        @(posedge clk);
        #1;
        v      = cpu_din;  // one clock after the address
        cpu_cs = 1'b0;
    endtask

    task automatic wait_sample();
        int n;
        for (n = 0; n < 600; n++) begin
            @(negedge clk);
            if (sample) return;
        end
        $display("wait_sample: no sample pulse within 600 clocks");
        $display("Test failed");
        $finish;
    endtask

    // engine held in reset while all registers are loaded, every channel stopped
    task automatic begin_config(input int watch);
        @(posedge clk);
        #2 rst = 1'b1;
        use_fill = 1'b0;
        watch_ch = watch;
        test_err = 0;
        exp_l    = 0;
        exp_r    = 0;
        exp_rom.delete();
        for (int c = 0; c < 8; c++) begin
            for (int o = 0; o < 16; o++) begin
                write_reg(c, 4'(o), (4'(o) == pcm_pkg::reg_enable) ? 8'h01 : 8'h00);
            end
        end
    endtask

    task automatic set_ch(input int ch, input logic [7:0] en, input logic [23:0] a,
                          input logic [7:0] delta, input logic [15:0] loop,
                          input logic [7:0] endb, input logic [7:0] vl, input logic [7:0] vr);
        write_reg(ch, pcm_pkg::reg_enable, en);
        write_reg(ch, pcm_pkg::reg_addr_lo, a[7:0]);
        write_reg(ch, pcm_pkg::reg_addr_mid, a[15:8]);
        write_reg(ch, pcm_pkg::reg_addr_hi, a[23:16]);
        write_reg(ch, pcm_pkg::reg_delta, delta);
        write_reg(ch, pcm_pkg::reg_loop_mid, loop[7:0]);
        write_reg(ch, pcm_pkg::reg_loop_hi, loop[15:8]);
        write_reg(ch, pcm_pkg::reg_end_hi, endb);
        write_reg(ch, pcm_pkg::reg_vol_l, vl);
        write_reg(ch, pcm_pkg::reg_vol_r, vr);
    endtask

    task automatic release_reset();
        @(posedge clk);
        #2 rst = 1'b0;
    endtask

    // one frame of the model: end rule, fetch, mix, address step
    task automatic model_frame();
        logic [7:0]  en;
        logic [23:0] a;
        logic [18:0] ra;
        logic [7:0]  b;
        int          s;
        int          sl;
        int          sr;
        sl = 0;
        sr = 0;
        for (int c = 0; c < 8; c++) begin
            en = regs_m[ridx(c, pcm_pkg::reg_enable)];
            a  = {regs_m[ridx(c, pcm_pkg::reg_addr_hi)], regs_m[ridx(c, pcm_pkg::reg_addr_mid)],
                  regs_m[ridx(c, pcm_pkg::reg_addr_lo)]};
            if (a[23:16] == regs_m[ridx(c, pcm_pkg::reg_end_hi)]) begin
                if (en[1]) begin
                    en[0]  = 1'b1;
                    a[7:0] = 8'd0;
                end else begin
                    a = {regs_m[ridx(c, pcm_pkg::reg_loop_hi)],
                         regs_m[ridx(c, pcm_pkg::reg_loop_mid)], 8'h00};
                end
            end
            ra = {en[6:4], a[23:8]};
            if (c == watch_ch) exp_rom.push_back(ra);
            b = use_fill ? fill : rom_byte(ra);
            s = int'(b) - 128;
            if (!en[0]) begin
                sl = clip(sl + int'(regs_m[ridx(c, pcm_pkg::reg_vol_l)][6:0]) * s);
                sr = clip(sr + int'(regs_m[ridx(c, pcm_pkg::reg_vol_r)][6:0]) * s);
            end
            a = a + {16'd0, regs_m[ridx(c, pcm_pkg::reg_delta)]};
            regs_m[ridx(c, pcm_pkg::reg_enable)]   = en;
            regs_m[ridx(c, pcm_pkg::reg_addr_lo)]  = a[7:0];
            regs_m[ridx(c, pcm_pkg::reg_addr_mid)] = a[15:8];
            regs_m[ridx(c, pcm_pkg::reg_addr_hi)]  = a[23:16];
        end
        exp_l = sl;
        exp_r = sr;
    endtask

    // pulse k shows the sums of frame k-1
    task automatic run_frames(input string name, input int n);
        for (int k = 1; k <= n; k++) begin
            wait_sample();
            check(name, "snd_left", exp_l, int'(snd_left));
            check(name, "snd_right", exp_r, int'(snd_right));
            if (k < n) begin
                model_frame();  // frame k runs until the next pulse
            end
        end
        if (rom_log.size() < n - 1) begin
            $display("%s: too few ROM requests for channel %0d", name, watch_ch);
            test_err++;
        end else begin
            for (int i = 0; i < n - 1; i++) check(name, "rom_addr", exp_rom[i], rom_log[i]);
        end
    endtask

    task automatic finish_test(input string name);
        $display("%s done, %0d errors", name, test_err);
        errors += test_err;
    endtask

    task automatic test_reset_idle();
        begin_config(0);
        release_reset();
        check("reset_idle", "rom_cs", 0, int'(rom_cs));
        check("reset_idle", "snd_left", 0, int'(snd_left));
        check("reset_idle", "snd_right", 0, int'(snd_right));
        run_frames("reset_idle", 4);
        finish_test("reset_idle");
    endtask

    task automatic test_readback();
        logic [7:0] v;
        begin_config(3);
        write_reg(1, pcm_pkg::reg_vol_l, 8'h5a);
        write_reg(4, pcm_pkg::reg_vol_r, 8'h33);
        write_reg(6, pcm_pkg::reg_delta, 8'hc7);
        set_ch(3, 8'h00, 24'h001000, 8'h10, 16'h0000, 8'hff, 8'h00, 8'h00);
        read_reg(1, pcm_pkg::reg_vol_l, v);
        check("readback", "vol_l ch1", 8'h5a, int'(v));
        read_reg(4, pcm_pkg::reg_vol_r, v);
        check("readback", "vol_r ch4", 8'h33, int'(v));
        read_reg(6, pcm_pkg::reg_delta, v);
        check("readback", "delta ch6", 8'hc7, int'(v));
        release_reset();
        run_frames("readback", 4);
        read_reg(3, pcm_pkg::reg_addr_lo, v);
        check("readback", "addr_lo ch3", int'(regs_m[ridx(3, pcm_pkg::reg_addr_lo)]), int'(v));
        read_reg(3, pcm_pkg::reg_addr_mid, v);
        check("readback", "addr_mid ch3", int'(regs_m[ridx(3, pcm_pkg::reg_addr_mid)]), int'(v));
        finish_test("readback");
    endtask

    task automatic test_play(input string name, input int ch, input logic [7:0] en,
                             input logic [23:0] a, input logic [7:0] delta,
                             input logic [15:0] loop, input logic [7:0] endb);
        logic [7:0] v;
        begin_config(ch);
        set_ch(ch, en, a, delta, loop, endb, 8'd64, 8'd32);
        release_reset();
        run_frames(name, 7);
        read_reg(ch, pcm_pkg::reg_enable, v);
        check(name, "enable byte", int'(regs_m[ridx(ch, pcm_pkg::reg_enable)]), int'(v));
        if (en[1] && !v[0]) begin
            $display("%s: channel did not stop at its end", name);
            test_err++;
        end
        finish_test(name);
    endtask

    task automatic test_saturation(input logic [7:0] b, input int lim);
        begin_config(0);
        for (int c = 0; c < 4; c++) set_ch(c, 8'h00, 24'h0, 8'h00, 16'h0, 8'hff, 8'd127, 8'd127);
        use_fill = 1'b1;
        fill     = b;
        release_reset();
        run_frames("saturation", 3);
        check("saturation", "snd_left", lim, int'(snd_left));
        check("saturation", "snd_right", lim, int'(snd_right));
        finish_test("saturation");
    endtask

    initial begin
        rst      = 1'b1;
        cen      = 1'b0;
        cpu_addr = 8'd0;
        cpu_dout = 8'd0;
        cpu_rnw  = 1'b1;
        cpu_cs   = 1'b0;
        rom_data = 8'd0;
        use_fill = 1'b0;
        fill     = 8'd0;
        watch_ch = 0;
        errors   = 0;
        repeat (10) @(posedge clk);
        test_reset_idle();
        test_readback();
        test_play("playback", 0, 8'h00, 24'h000100, 8'h40, 16'h0000, 8'hff);
        test_play("looping", 0, 8'h10, 24'h00ff00, 8'hff, 16'h0020, 8'h01);
        test_play("one_shot", 2, 8'h02, 24'h02ff00, 8'hff, 16'h0000, 8'h03);
        test_saturation(8'hff, 32767);
        test_saturation(8'h00, -32768);
        $display("all tests done, %0d errors", errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
